// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_axi_wr_3to2
FILELIST := tb.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== rtl/axi_wr_3to2.sv ====
`default_nettype none

module axi_wr_3to2 (
  input  wire logic                          axi_clk,
  input  wire logic                          axi_resetn,

  input  wire logic [axi_wr_pkg::ADDR_W-1:0] m0_awaddr,
  input  wire logic                          m0_awvalid,
  output logic                               m0_awready,
  input  wire logic [axi_wr_pkg::DATA_W-1:0] m0_wdata,
  input  wire logic [axi_wr_pkg::STRB_W-1:0] m0_wstrb,
  input  wire logic                          m0_wvalid,
  output logic                               m0_wready,
  output logic      [axi_wr_pkg::RESP_W-1:0] m0_bresp,
  output logic                               m0_bvalid,
  input  wire logic                          m0_bready,

  input  wire logic [axi_wr_pkg::ADDR_W-1:0] m1_awaddr,
  input  wire logic                          m1_awvalid,
  output logic                               m1_awready,
  input  wire logic [axi_wr_pkg::DATA_W-1:0] m1_wdata,
  input  wire logic [axi_wr_pkg::STRB_W-1:0] m1_wstrb,
  input  wire logic                          m1_wvalid,
  output logic                               m1_wready,
  output logic      [axi_wr_pkg::RESP_W-1:0] m1_bresp,
  output logic                               m1_bvalid,
  input  wire logic                          m1_bready,

  input  wire logic [axi_wr_pkg::ADDR_W-1:0] m2_awaddr,
  input  wire logic                          m2_awvalid,
  output logic                               m2_awready,
  input  wire logic [axi_wr_pkg::DATA_W-1:0] m2_wdata,
  input  wire logic [axi_wr_pkg::STRB_W-1:0] m2_wstrb,
  input  wire logic                          m2_wvalid,
  output logic                               m2_wready,
  output logic      [axi_wr_pkg::RESP_W-1:0] m2_bresp,
  output logic                               m2_bvalid,
  input  wire logic                          m2_bready,

  // even addresses
  output logic      [axi_wr_pkg::ADDR_W-1:0] s0_awaddr,
  output logic                               s0_awvalid,
  input  wire logic                          s0_awready,
  output logic      [axi_wr_pkg::DATA_W-1:0] s0_wdata,
  output logic      [axi_wr_pkg::STRB_W-1:0] s0_wstrb,
  output logic                               s0_wvalid,
  input  wire logic                          s0_wready,
  input  wire logic [axi_wr_pkg::RESP_W-1:0] s0_bresp,
  input  wire logic                          s0_bvalid,
  output logic                               s0_bready,

  // odd addresses
  output logic      [axi_wr_pkg::ADDR_W-1:0] s1_awaddr,
  output logic                               s1_awvalid,
  input  wire logic                          s1_awready,
  output logic      [axi_wr_pkg::DATA_W-1:0] s1_wdata,
  output logic      [axi_wr_pkg::STRB_W-1:0] s1_wstrb,
  output logic                               s1_wvalid,
  input  wire logic                          s1_wready,
  input  wire logic [axi_wr_pkg::RESP_W-1:0] s1_bresp,
  input  wire logic                          s1_bvalid,
  output logic                               s1_bready
);

  logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::ADDR_W-1:0] mgr_awaddr;
  logic [axi_wr_pkg::NUM_MGR-1:0]                         mgr_awvalid;
  logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::DATA_W-1:0] mgr_wdata;
  logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::STRB_W-1:0] mgr_wstrb;
  logic [axi_wr_pkg::NUM_MGR-1:0]                         mgr_wvalid;
  logic [axi_wr_pkg::NUM_MGR-1:0]                         mgr_bready;
  logic [axi_wr_pkg::NUM_MGR-1:0]                         odd_addr;

  assign mgr_awaddr  = {m2_awaddr, m1_awaddr, m0_awaddr};
  assign mgr_awvalid = {m2_awvalid, m1_awvalid, m0_awvalid};
  assign mgr_wdata   = {m2_wdata, m1_wdata, m0_wdata};
  assign mgr_wstrb   = {m2_wstrb, m1_wstrb, m0_wstrb};
  assign mgr_wvalid  = {m2_wvalid, m1_wvalid, m0_wvalid};
  assign mgr_bready  = {m2_bready, m1_bready, m0_bready};

  // address bit 0 picks the subordinate
  assign odd_addr = {m2_awaddr[0], m1_awaddr[0], m0_awaddr[0]};

  logic [axi_wr_pkg::NUM_MGR-1:0]                         ch0_awready;
  logic [axi_wr_pkg::NUM_MGR-1:0]                         ch0_wready;
  logic [axi_wr_pkg::NUM_MGR-1:0]                         ch0_bvalid;
  logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::RESP_W-1:0] ch0_bresp;
  logic [axi_wr_pkg::NUM_MGR-1:0]                         ch1_awready;
  logic [axi_wr_pkg::NUM_MGR-1:0]                         ch1_wready;
  logic [axi_wr_pkg::NUM_MGR-1:0]                         ch1_bvalid;
  logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::RESP_W-1:0] ch1_bresp;

  write_channel ch0 (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .request    (mgr_awvalid & ~odd_addr),
    .mgr_awaddr (mgr_awaddr),
    .mgr_awvalid(mgr_awvalid),
    .mgr_awready(ch0_awready),
    .mgr_wdata  (mgr_wdata),
    .mgr_wstrb  (mgr_wstrb),
    .mgr_wvalid (mgr_wvalid),
    .mgr_wready (ch0_wready),
    .mgr_bresp  (ch0_bresp),
    .mgr_bvalid (ch0_bvalid),
    .mgr_bready (mgr_bready),
    .sub_awaddr (s0_awaddr),
    .sub_awvalid(s0_awvalid),
    .sub_awready(s0_awready),
    .sub_wdata  (s0_wdata),
    .sub_wstrb  (s0_wstrb),
    .sub_wvalid (s0_wvalid),
    .sub_wready (s0_wready),
    .sub_bresp  (s0_bresp),
    .sub_bvalid (s0_bvalid),
    .sub_bready (s0_bready)
  );

  write_channel ch1 (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .request    (mgr_awvalid & odd_addr),
    .mgr_awaddr (mgr_awaddr),
    .mgr_awvalid(mgr_awvalid),
    .mgr_awready(ch1_awready),
    .mgr_wdata  (mgr_wdata),
    .mgr_wstrb  (mgr_wstrb),
    .mgr_wvalid (mgr_wvalid),
    .mgr_wready (ch1_wready),
    .mgr_bresp  (ch1_bresp),
    .mgr_bvalid (ch1_bvalid),
    .mgr_bready (mgr_bready),
    .sub_awaddr (s1_awaddr),
    .sub_awvalid(s1_awvalid),
    .sub_awready(s1_awready),
    .sub_wdata  (s1_wdata),
    .sub_wstrb  (s1_wstrb),
    .sub_wvalid (s1_wvalid),
    .sub_wready (s1_wready),
    .sub_bresp  (s1_bresp),
    .sub_bvalid (s1_bvalid),
    .sub_bready (s1_bready)
  );

  // a manager is granted by one channel at a time, so OR is a merge
  assign m0_awready = ch0_awready[0] | ch1_awready[0];
  assign m1_awready = ch0_awready[1] | ch1_awready[1];
  assign m2_awready = ch0_awready[2] | ch1_awready[2];

  assign m0_wready = ch0_wready[0] | ch1_wready[0];
  assign m1_wready = ch0_wready[1] | ch1_wready[1];
  assign m2_wready = ch0_wready[2] | ch1_wready[2];

  assign m0_bvalid = ch0_bvalid[0] | ch1_bvalid[0];
  assign m1_bvalid = ch0_bvalid[1] | ch1_bvalid[1];
  assign m2_bvalid = ch0_bvalid[2] | ch1_bvalid[2];

  assign m0_bresp = ch0_bresp[0] | ch1_bresp[0];
  assign m1_bresp = ch0_bresp[1] | ch1_bresp[1];
  assign m2_bresp = ch0_bresp[2] | ch1_bresp[2];

endmodule

`default_nettype wire

// ==== rtl/axi_wr_pkg.sv ====
`default_nettype none

// widths and counts of the AXI-Lite write channels
package axi_wr_pkg;

  // address passed through to the subordinates unchanged
  localparam int ADDR_W = 20;

  localparam int DATA_W = 16;

  // one strobe bit per data byte
  localparam int STRB_W = (DATA_W + 7) / 8;

  // OKAY, EXOKAY, SLVERR, DECERR
  localparam int RESP_W = 2;

  localparam int NUM_MGR = 3;

endpackage

`default_nettype wire

// ==== rtl/grant_pkg.sv ====
`default_nettype none

// grant encoding shared by arbiter, grant queue and port mux
package grant_pkg;

  // wide enough for every manager index plus the idle code
  localparam int GRANT_W = 2;

  // no manager granted
  localparam logic [GRANT_W-1:0] GRANT_IDLE = '1;

  // accepted writes that may wait for their B response
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_AW = 2;

endpackage

`default_nettype wire

// ==== rtl/grant_queue.sv ====
`default_nettype none

module grant_queue (
  input  wire logic                         axi_clk,
  input  wire logic                         axi_resetn,
  input  wire logic                         push,
  input  wire logic [grant_pkg::GRANT_W-1:0] push_grant,
  input  wire logic                         pop,
  output logic      [grant_pkg::GRANT_W-1:0] resp_grant
);

  logic [grant_pkg::GRANT_W-1:0] mem [grant_pkg::QUEUE_DEPTH];
  logic [grant_pkg::QUEUE_AW-1:0] wr_ptr;
  logic [grant_pkg::QUEUE_AW-1:0] rd_ptr;
  logic [grant_pkg::QUEUE_AW:0]   count;
  logic                           empty;
  logic                           full;
  logic                           do_pop;

  assign empty  = count == '0;
  assign full   = int'(count) == grant_pkg::QUEUE_DEPTH;
  assign do_pop = pop && !empty;

  always_ff @(posedge axi_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_grant;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // oldest accepted write owns the response channel
  assign resp_grant = empty ? grant_pkg::GRANT_IDLE : mem[rd_ptr];

  // more accepted writes in flight than slots would lose a response route
  no_push_when_full: assert property (
    @(posedge axi_clk) disable iff (!axi_resetn)
    !(push && full)
  );

endmodule

`default_nettype wire

// ==== rtl/write_arbiter.sv ====
`default_nettype none

module write_arbiter (
  input  wire logic                          axi_clk,
  input  wire logic                          axi_resetn,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0] request,
  input  wire logic                          sub_awvalid,
  input  wire logic                          sub_awready,
  input  wire logic                          sub_wvalid,
  input  wire logic                          sub_wready,
  output logic      [grant_pkg::GRANT_W-1:0] req_grant,
  output logic                               accepted
);

  logic                            idle;
  logic                            aw_hs;
  logic                            w_hs;
  logic                            aw_done;
  logic                            w_done;
  logic [axi_wr_pkg::NUM_MGR-1:0]  candidates;
  logic [grant_pkg::GRANT_W-1:0]   next_grant;

  assign idle  = req_grant == grant_pkg::GRANT_IDLE;
  assign aw_hs = sub_awvalid && sub_awready;
  assign w_hs  = sub_wvalid && sub_wready;

  // both halves done, in this cycle or earlier in the same grant
  assign accepted = (aw_done || aw_hs) && (w_done || w_hs);

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (accepted) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      aw_done <= aw_done || aw_hs;
      w_done  <= w_done || w_hs;
    end
  end

  // the holder drops out of the next choice so others get a turn
  always_comb begin
    candidates = request;
    if (!idle) begin
      candidates[req_grant] = 1'b0;
    end
  end

  always_comb begin
    next_grant = req_grant;
    if (idle || accepted) begin
      next_grant = grant_pkg::GRANT_IDLE;
      // walk down so that manager 0 wins ties
      for (int i = axi_wr_pkg::NUM_MGR - 1; i >= 0; i--) begin
        if (candidates[i]) begin
          next_grant = i[grant_pkg::GRANT_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      req_grant <= grant_pkg::GRANT_IDLE;
    end else begin
      req_grant <= next_grant;
    end
  end

  // an acceptance while idle would queue the idle code as a response route
  no_accept_when_idle: assert property (
    @(posedge axi_clk) disable iff (!axi_resetn)
    idle |-> !accepted
  );

  // a manager keeps the grant until its write is accepted
  grant_held: assert property (
    @(posedge axi_clk) disable iff (!axi_resetn)
    (!idle && !accepted) |=> $stable(req_grant)
  );

endmodule

`default_nettype wire

// ==== rtl/write_channel.sv ====
`default_nettype none

module write_channel (
  input  wire logic                                                 axi_clk,
  input  wire logic                                                 axi_resetn,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0]                       request,

  input  wire logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::ADDR_W-1:0] mgr_awaddr,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0]                       mgr_awvalid,
  output logic      [axi_wr_pkg::NUM_MGR-1:0]                       mgr_awready,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::DATA_W-1:0] mgr_wdata,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::STRB_W-1:0] mgr_wstrb,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0]                       mgr_wvalid,
  output logic      [axi_wr_pkg::NUM_MGR-1:0]                       mgr_wready,
  output logic      [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::RESP_W-1:0] mgr_bresp,
  output logic      [axi_wr_pkg::NUM_MGR-1:0]                       mgr_bvalid,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0]                       mgr_bready,

  output logic      [axi_wr_pkg::ADDR_W-1:0]                        sub_awaddr,
  output logic                                                      sub_awvalid,
  input  wire logic                                                 sub_awready,
  output logic      [axi_wr_pkg::DATA_W-1:0]                        sub_wdata,
  output logic      [axi_wr_pkg::STRB_W-1:0]                        sub_wstrb,
  output logic                                                      sub_wvalid,
  input  wire logic                                                 sub_wready,
  input  wire logic [axi_wr_pkg::RESP_W-1:0]                        sub_bresp,
  input  wire logic                                                 sub_bvalid,
  output logic                                                      sub_bready
);

  logic [grant_pkg::GRANT_W-1:0] req_grant;
  logic [grant_pkg::GRANT_W-1:0] resp_grant;
  logic                          accepted;
  logic                          b_hs;

  // a completed response frees the head of the queue
  assign b_hs = sub_bvalid && sub_bready;

  write_arbiter arb (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .request    (request),
    .sub_awvalid(sub_awvalid),
    .sub_awready(sub_awready),
    .sub_wvalid (sub_wvalid),
    .sub_wready (sub_wready),
    .req_grant  (req_grant),
    .accepted   (accepted)
  );

  grant_queue queue (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .push      (accepted),
    .push_grant(req_grant),
    .pop       (b_hs),
    .resp_grant(resp_grant)
  );

  write_port_mux mux (
    .req_grant  (req_grant),
    .resp_grant (resp_grant),
    .mgr_awaddr (mgr_awaddr),
    .mgr_awvalid(mgr_awvalid),
    .mgr_awready(mgr_awready),
    .mgr_wdata  (mgr_wdata),
    .mgr_wstrb  (mgr_wstrb),
    .mgr_wvalid (mgr_wvalid),
    .mgr_wready (mgr_wready),
    .mgr_bresp  (mgr_bresp),
    .mgr_bvalid (mgr_bvalid),
    .mgr_bready (mgr_bready),
    .sub_awaddr (sub_awaddr),
    .sub_awvalid(sub_awvalid),
    .sub_awready(sub_awready),
    .sub_wdata  (sub_wdata),
    .sub_wstrb  (sub_wstrb),
    .sub_wvalid (sub_wvalid),
    .sub_wready (sub_wready),
    .sub_bresp  (sub_bresp),
    .sub_bvalid (sub_bvalid),
    .sub_bready (sub_bready)
  );

endmodule

`default_nettype wire

// ==== rtl/write_port_mux.sv ====
`default_nettype none

module write_port_mux (
  input  wire logic [grant_pkg::GRANT_W-1:0]                        req_grant,
  input  wire logic [grant_pkg::GRANT_W-1:0]                        resp_grant,

  // manager side, one lane per manager
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::ADDR_W-1:0] mgr_awaddr,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0]                       mgr_awvalid,
  output logic      [axi_wr_pkg::NUM_MGR-1:0]                       mgr_awready,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::DATA_W-1:0] mgr_wdata,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::STRB_W-1:0] mgr_wstrb,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0]                       mgr_wvalid,
  output logic      [axi_wr_pkg::NUM_MGR-1:0]                       mgr_wready,
  output logic      [axi_wr_pkg::NUM_MGR-1:0][axi_wr_pkg::RESP_W-1:0] mgr_bresp,
  output logic      [axi_wr_pkg::NUM_MGR-1:0]                       mgr_bvalid,
  input  wire logic [axi_wr_pkg::NUM_MGR-1:0]                       mgr_bready,

  // subordinate side
  output logic      [axi_wr_pkg::ADDR_W-1:0]                        sub_awaddr,
  output logic                                                      sub_awvalid,
  input  wire logic                                                 sub_awready,
  output logic      [axi_wr_pkg::DATA_W-1:0]                        sub_wdata,
  output logic      [axi_wr_pkg::STRB_W-1:0]                        sub_wstrb,
  output logic                                                      sub_wvalid,
  input  wire logic                                                 sub_wready,
  input  wire logic [axi_wr_pkg::RESP_W-1:0]                        sub_bresp,
  input  wire logic                                                 sub_bvalid,
  output logic                                                      sub_bready
);

  // address and data phases follow the request grant
  always_comb begin
    sub_awaddr  = '0;
    sub_awvalid = 1'b0;
    sub_wdata   = '0;
    sub_wstrb   = '0;
    sub_wvalid  = 1'b0;
    mgr_awready = '0;
    mgr_wready  = '0;
    if (req_grant != grant_pkg::GRANT_IDLE) begin
      sub_awaddr             = mgr_awaddr[req_grant];
      sub_awvalid            = mgr_awvalid[req_grant];
      sub_wdata              = mgr_wdata[req_grant];
      sub_wstrb              = mgr_wstrb[req_grant];
      sub_wvalid             = mgr_wvalid[req_grant];
      mgr_awready[req_grant] = sub_awready;
      mgr_wready[req_grant]  = sub_wready;
    end
  end

  // response phase follows the queue head, which may be an older write
  always_comb begin
    sub_bready = 1'b0;
    mgr_bvalid = '0;
    mgr_bresp  = '0;
    if (resp_grant != grant_pkg::GRANT_IDLE) begin
      sub_bready             = mgr_bready[resp_grant];
      mgr_bvalid[resp_grant] = sub_bvalid;
      mgr_bresp[resp_grant]  = sub_bresp;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/axi_wr_pkg.sv
rtl/grant_pkg.sv
rtl/write_arbiter.sv
rtl/grant_queue.sv
rtl/write_port_mux.sv
rtl/write_channel.sv
rtl/axi_wr_3to2.sv
test/tb_axi_wr_3to2.sv

// ==== test/tb_axi_wr_3to2.sv ====
`default_nettype none

// answers each write with bresp taken from bits 2:1 of its address
module subordinate_model (
  input  wire logic                          axi_clk,
  input  wire logic                          axi_resetn,
  input  wire logic [axi_wr_pkg::ADDR_W-1:0] awaddr,
  input  wire logic                          awvalid,
  output logic                               awready,
  input  wire logic                          wvalid,
  output logic                               wready,
  output logic      [axi_wr_pkg::RESP_W-1:0] bresp,
  output logic                               bvalid,
  input  wire logic                          bready
);

  logic [axi_wr_pkg::ADDR_W-1:0] aw_q [$];
  logic [axi_wr_pkg::ADDR_W-1:0] addr_s;
  logic                          aw_hs;
  logic                          w_hs;
  logic                          b_hs;
  logic                          rst_s;
  int                            w_cnt;

  initial begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = '0;
    w_cnt   = 0;
    forever begin
      @(negedge axi_clk);
      rst_s  = !axi_resetn;
      addr_s = awaddr;
      aw_hs  = awvalid && awready;
      w_hs   = wvalid && wready;
      b_hs   = bvalid && bready;
      @(posedge axi_clk);
      #10;
      if (rst_s) begin
        aw_q.delete();
        w_cnt   = 0;
        bvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
      end else begin
        if (aw_hs) aw_q.push_back(addr_s);
        if (w_hs) w_cnt++;
        if (b_hs) begin
          bvalid = 1'b0;
          void'(aw_q.pop_front());
          w_cnt--;
        end
        if (!bvalid && aw_q.size() > 0 && w_cnt > 0) begin
          bvalid = 1'b1;
          bresp  = aw_q[0][2:1];
        end
        // ready about three cycles in four
        awready = ($urandom % 4) != 0;
        wready  = ($urandom % 4) != 0;
      end
    end
  end

endmodule

module tb_axi_wr_3to2;

  localparam int DRIVE_DELAY = 10;
  localparam int TIMEOUT = 300;

  logic axi_clk;
  logic axi_resetn;
  logic [axi_wr_pkg::ADDR_W-1:0] m_awaddr [3];
  logic [axi_wr_pkg::DATA_W-1:0] m_wdata [3];
  logic [1:0]                    m_wstrb [3];
  logic [axi_wr_pkg::RESP_W-1:0] m_bresp [3];
  logic [axi_wr_pkg::RESP_W-1:0] exp_resp [3];
  logic [2:0] m_awvalid, m_wvalid, m_bready, m_awready, m_wready, m_bvalid;
  logic [2:0] phase_b;
  logic [axi_wr_pkg::ADDR_W-1:0] s0_awaddr, s1_awaddr;
  logic [axi_wr_pkg::DATA_W-1:0] s0_wdata, s1_wdata;
  logic [1:0] s0_wstrb, s1_wstrb;
  logic [axi_wr_pkg::RESP_W-1:0] s0_bresp, s1_bresp;
  logic s0_awvalid, s0_awready, s0_wvalid, s0_wready, s0_bvalid, s0_bready;
  logic s1_awvalid, s1_awready, s1_wvalid, s1_wready, s1_bvalid, s1_bready;
  logic idle_done;
  logic fair_on;
  int   overlap_count;
  int   overlap_base;
  int   s0_aw_count;
  int   round_base;
  int   issued [3];
  int   done_cnt [3];
  int   errors;
  int   tests;

  axi_wr_3to2 DUT (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .m0_awaddr(m_awaddr[0]), .m0_awvalid(m_awvalid[0]), .m0_awready(m_awready[0]),
    .m0_wdata(m_wdata[0]), .m0_wstrb(m_wstrb[0]), .m0_wvalid(m_wvalid[0]),
    .m0_wready(m_wready[0]), .m0_bresp(m_bresp[0]), .m0_bvalid(m_bvalid[0]),
    .m0_bready(m_bready[0]),
    .m1_awaddr(m_awaddr[1]), .m1_awvalid(m_awvalid[1]), .m1_awready(m_awready[1]),
    .m1_wdata(m_wdata[1]), .m1_wstrb(m_wstrb[1]), .m1_wvalid(m_wvalid[1]),
    .m1_wready(m_wready[1]), .m1_bresp(m_bresp[1]), .m1_bvalid(m_bvalid[1]),
    .m1_bready(m_bready[1]),
    .m2_awaddr(m_awaddr[2]), .m2_awvalid(m_awvalid[2]), .m2_awready(m_awready[2]),
    .m2_wdata(m_wdata[2]), .m2_wstrb(m_wstrb[2]), .m2_wvalid(m_wvalid[2]),
    .m2_wready(m_wready[2]), .m2_bresp(m_bresp[2]), .m2_bvalid(m_bvalid[2]),
    .m2_bready(m_bready[2]),
    .s0_awaddr(s0_awaddr), .s0_awvalid(s0_awvalid), .s0_awready(s0_awready),
    .s0_wdata(s0_wdata), .s0_wstrb(s0_wstrb), .s0_wvalid(s0_wvalid),
    .s0_wready(s0_wready), .s0_bresp(s0_bresp), .s0_bvalid(s0_bvalid),
    .s0_bready(s0_bready),
    .s1_awaddr(s1_awaddr), .s1_awvalid(s1_awvalid), .s1_awready(s1_awready),
    .s1_wdata(s1_wdata), .s1_wstrb(s1_wstrb), .s1_wvalid(s1_wvalid),
    .s1_wready(s1_wready), .s1_bresp(s1_bresp), .s1_bvalid(s1_bvalid),
    .s1_bready(s1_bready)
  );

  subordinate_model s0_model (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn), .awaddr(s0_awaddr),
    .awvalid(s0_awvalid), .awready(s0_awready), .wvalid(s0_wvalid),
    .wready(s0_wready), .bresp(s0_bresp), .bvalid(s0_bvalid), .bready(s0_bready)
  );

  subordinate_model s1_model (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn), .awaddr(s1_awaddr),
    .awvalid(s1_awvalid), .awready(s1_awready), .wvalid(s1_wvalid),
    .wready(s1_wready), .bresp(s1_bresp), .bvalid(s1_bvalid), .bready(s1_bready)
  );

  // write data and strobe are fixed functions of the address
  function automatic logic [axi_wr_pkg::DATA_W-1:0] data_for(
    input logic [axi_wr_pkg::ADDR_W-1:0] a
  );
    return a[axi_wr_pkg::DATA_W-1:0] ^ 16'h5a3c;
  endfunction

  function automatic logic [1:0] strb_for(input logic [axi_wr_pkg::ADDR_W-1:0] a);
    return {a[6], 1'b1};
  endfunction

  // bits 5:4 carry the manager index, bits 3:1 are random
  function automatic logic [axi_wr_pkg::ADDR_W-1:0] make_addr(
    input int k, input int n, input logic odd
  );
    logic [axi_wr_pkg::ADDR_W-1:0] a;
    a = '0;
    a[axi_wr_pkg::ADDR_W-1:6] = n[axi_wr_pkg::ADDR_W-7:0];
    a[5:4] = k[1:0];
    a[3:1] = 3'($urandom);
    a[0] = odd;
    return a;
  endfunction

  initial begin
    axi_clk = 1'b0;
    forever #50 axi_clk = ~axi_clk;
  end

  always @(posedge axi_clk) begin
    if (!axi_resetn) begin
      s0_aw_count   <= 0;
      overlap_count <= 0;
    end else begin
      if (s0_awvalid && s0_awready) s0_aw_count <= s0_aw_count + 1;
      if (s0_awvalid && s1_awvalid) overlap_count <= overlap_count + 1;
    end
  end

  // nothing moves before the first request
  idle_after_reset: assert property (@(posedge axi_clk)
    (axi_resetn && !idle_done && m_awvalid == 3'b000) |->
    ({s0_awvalid, s0_wvalid, s0_bready, s1_awvalid, s1_wvalid, s1_bready,
      m_awready, m_wready, m_bvalid} == 15'h0))
    else begin
      errors++;
      $display("Fail t=%0t idle outputs expected 0 got %b", $time,
               {s0_awvalid, s0_wvalid, s0_bready, s1_awvalid, s1_wvalid, s1_bready,
                m_awready, m_wready, m_bvalid});
    end

  s0_addr_route: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    s0_awvalid |-> (s0_awaddr[0] == 1'b0 && s0_awaddr[5:4] != 2'd3 &&
                    m_awvalid[s0_awaddr[5:4]] && m_awaddr[s0_awaddr[5:4]] == s0_awaddr))
    else begin
      errors++;
      $display("Fail t=%0t s0_awaddr expected %h got %h", $time,
               m_awaddr[s0_awaddr[5:4]], s0_awaddr);
    end

  s1_addr_route: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    s1_awvalid |-> (s1_awaddr[0] == 1'b1 && s1_awaddr[5:4] != 2'd3 &&
                    m_awvalid[s1_awaddr[5:4]] && m_awaddr[s1_awaddr[5:4]] == s1_awaddr))
    else begin
      errors++;
      $display("Fail t=%0t s1_awaddr expected %h got %h", $time,
               m_awaddr[s1_awaddr[5:4]], s1_awaddr);
    end

  s0_data_route: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    s0_wvalid |-> (s0_wdata == data_for(s0_awaddr) && s0_wstrb == strb_for(s0_awaddr)))
    else begin
      errors++;
      $display("Fail t=%0t s0_wdata expected %h got %h", $time,
               data_for(s0_awaddr), s0_wdata);
    end

  s1_data_route: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    s1_wvalid |-> (s1_wdata == data_for(s1_awaddr) && s1_wstrb == strb_for(s1_awaddr)))
    else begin
      errors++;
      $display("Fail t=%0t s1_wdata expected %h got %h", $time,
               data_for(s1_awaddr), s1_wdata);
    end

  // first address of a contended round belongs to manager 0
  priority_first: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (fair_on && s0_awvalid && s0_awready && s0_aw_count == round_base) |->
    s0_awaddr[5:4] == 2'd0)
    else begin
      errors++;
      $display("Fail t=%0t s0_awaddr[5:4] expected 0 got %0d", $time, s0_awaddr[5:4]);
    end

  for (genvar g = 0; g < 3; g++) begin : per_mgr
    b_only_when_owed: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
      m_bvalid[g] |-> phase_b[g])
      else begin
        errors++;
        $display("Fail t=%0t m%0d_bvalid expected 0 got 1", $time, g);
      end

    b_resp_value: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
      m_bvalid[g] |-> m_bresp[g] == exp_resp[g])
      else begin
        errors++;
        $display("Fail t=%0t m%0d_bresp expected %0d got %0d", $time, g,
                 exp_resp[g], m_bresp[g]);
      end
  end

  task automatic write_once(input int k, input logic [axi_wr_pkg::ADDR_W-1:0] addr);
    logic aw_ok;
    logic w_ok;
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    int   waited;
    aw_ok = 1'b0;
    w_ok = 1'b0;
    b_hs = 1'b0;
    waited = 0;
    issued[k]++;
    m_awaddr[k] = addr;
    m_wdata[k] = data_for(addr);
    m_wstrb[k] = strb_for(addr);
    exp_resp[k] = addr[2:1];
    m_awvalid[k] = 1'b1;
    m_wvalid[k] = 1'b1;
    while (!(aw_ok && w_ok) && waited < TIMEOUT) begin
      @(negedge axi_clk);
      aw_hs = m_awvalid[k] && m_awready[k];
      w_hs = m_wvalid[k] && m_wready[k];
      @(posedge axi_clk);
      #DRIVE_DELAY;
      if (aw_hs) begin
        aw_ok = 1'b1;
        m_awvalid[k] = 1'b0;
      end
      if (w_hs) begin
        w_ok = 1'b1;
        m_wvalid[k] = 1'b0;
      end
      waited++;
    end
    if (!(aw_ok && w_ok)) begin
      errors++;
      $display("timeout: manager %0d write to %h was never accepted", k, addr);
      m_awvalid[k] = 1'b0;
      m_wvalid[k] = 1'b0;
      return;
    end
    phase_b[k] = 1'b1;
    waited = 0;
    while (!b_hs && waited < TIMEOUT) begin
      @(negedge axi_clk);
      b_hs = m_bvalid[k] && m_bready[k];
      @(posedge axi_clk);
      #DRIVE_DELAY;
      waited++;
    end
    phase_b[k] = 1'b0;
    if (!b_hs) begin
      errors++;
      $display("timeout: manager %0d got no write response for %h", k, addr);
    end else begin
      done_cnt[k]++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s finished, errors so far %0d", tests, name, errors);
  endtask

  initial begin
    void'($urandom(76));
    axi_resetn = 1'b0;
    m_awvalid = '0;
    m_wvalid = '0;
    m_bready = 3'b111;
    phase_b = '0;
    idle_done = 1'b0;
    fair_on = 1'b0;
    overlap_base = 0;
    round_base = 0;
    errors = 0;
    tests = 0;
    for (int k = 0; k < 3; k++) begin
      m_awaddr[k] = '0;
      m_wdata[k] = '0;
      m_wstrb[k] = '0;
      exp_resp[k] = '0;
      issued[k] = 0;
      done_cnt[k] = 0;
    end
    repeat (2) @(posedge axi_clk);
    #DRIVE_DELAY;
    axi_resetn = 1'b1;

    repeat (3) @(posedge axi_clk);
    #DRIVE_DELAY;
    idle_done = 1'b1;
    finish_test("idle after reset");

    for (int k = 0; k < 3; k++) begin
      write_once(k, make_addr(k, 1, 1'b0));
      write_once(k, make_addr(k, 2, 1'b1));
    end
    finish_test("parity routing");

    fork
      for (int n = 0; n < 4; n++) write_once(0, make_addr(0, 10 + n, 1'($urandom)));
      for (int n = 0; n < 4; n++) write_once(1, make_addr(1, 20 + n, 1'($urandom)));
      for (int n = 0; n < 4; n++) write_once(2, make_addr(2, 30 + n, 1'($urandom)));
    join
    finish_test("response routing");

    fair_on = 1'b1;
    for (int r = 0; r < 2; r++) begin
      round_base = s0_aw_count;
      fork
        write_once(0, make_addr(0, 40 + r, 1'b0));
        write_once(1, make_addr(1, 40 + r, 1'b0));
        write_once(2, make_addr(2, 40 + r, 1'b0));
      join
    end
    fair_on = 1'b0;
    finish_test("priority and yield");

    overlap_base = overlap_count;
    fork
      write_once(1, make_addr(1, 50, 1'b0));
      write_once(2, make_addr(2, 50, 1'b1));
    join
    overlap_seen: assert (overlap_count > overlap_base)
      else begin
        errors++;
        $display("s0 and s1 were never in their address phase together");
      end
    finish_test("parallel address phases");

    m_bready[0] = 1'b0;
    fork
      write_once(0, make_addr(0, 60, 1'b0));
      begin
        repeat (2) @(posedge axi_clk);
        #DRIVE_DELAY;
        write_once(1, make_addr(1, 60, 1'b0));
        write_once(1, make_addr(1, 61, 1'b1));
      end
      write_once(2, make_addr(2, 60, 1'b1));
      begin
        repeat (15) @(posedge axi_clk);
        #DRIVE_DELAY;
        m_bready[0] = 1'b1;
      end
    join
    for (int k = 0; k < 3; k++) begin
      none_lost: assert (done_cnt[k] == issued[k])
        else begin
          errors++;
          $display("Fail t=%0t m%0d responses expected %0d got %0d", $time, k,
                   issued[k], done_cnt[k]);
        end
    end
    finish_test("held response");

    $display("tests run: %0d, failed checks: %0d", tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
